// ==== all.f ====
gmii_rx_pkg.sv
gmii_phy_rx_if.sv
gmii_rx_framer.sv
frame_buf_arbiter.sv
frame_buf_ram.sv
wb_frame_host.sv
gmii_rx_subsys.sv
gmii_rx_checker.sv
tb_gmii_rx_subsys.sv

// ==== Bender.yml ====
package:
  name: gmii_rx_subsys

sources:
  - gmii_rx_pkg.sv
  - gmii_phy_rx_if.sv
  - gmii_rx_framer.sv
  - frame_buf_arbiter.sv
  - frame_buf_ram.sv
  - wb_frame_host.sv
  - gmii_rx_subsys.sv
  - target: simulation
    files:
      - gmii_rx_checker.sv
      - tb_gmii_rx_subsys.sv

// ==== tb_gmii_rx_subsys.sv ====
// ##########################################################
// Testbench for the GMII receive subsystem
// Clock and reset, GMII frame generator with reference FCS
// Wishbone read and write tasks, slot and status checks
// Watchdog and bus checker watch
// ##########################################################

`timescale 1ns/1ns

module tb_gmii_rx_subsys
    import gmii_rx_pkg::*;
();

    localparam int clk_period = 100;

    // Payload sizes of the six frames, FCS not included
    localparam int len_good   = 64;
    localparam int len_badfcs = 41;
    localparam int len_rxer   = 32;
    localparam int len_long   = 296;
    localparam int len_drop   = 20;
    localparam int len_reuse  = 46;
    localparam int len_sum    = len_good + len_badfcs + len_rxer + len_long + len_drop
                                + len_reuse;

    // FCS, preamble, SFD and gap per frame
    localparam int frame_cycles    = len_sum + 6 * (4 + 8 + 12);
    localparam int bus_cycles      = 8 * (len_sum / 4 + 6 * 4);
    localparam int watchdog_cycles = 8 + 4 + frame_cycles + bus_cycles + 200;

    localparam int ack_limit = 32;

    logic        mac_gmii_rx_clk;
    logic        rst;
    logic [7:0]  phy_gmii_rxd;
    logic        phy_gmii_rx_dv;
    logic        phy_gmii_rx_er;
    logic [8:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    // Bytes of the last frame after the SFD, FCS included
    logic [7:0]  frame_bytes [0:511];
    int          frame_len;
    logic [31:0] rng_state;

    gmii_rx_subsys u_gmii_rx_subsys (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_we           (wb_we),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_dat_o        (wb_dat_o),
        .wb_ack          (wb_ack)
    );

    initial begin
        mac_gmii_rx_clk = 1'b0;
        forever #(clk_period / 2) mac_gmii_rx_clk = ~mac_gmii_rx_clk;
    end

    // xorshift32 payload source
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Ack sampled on the falling edge, away from the DUT update
    task automatic wait_ack(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge mac_gmii_rx_clk);
            cycles++;
            if (cycles > ack_limit) begin
                $display("No Wishbone acknowledge for the %s at %0t ns", what, $time);
                $display("Simulation failed");
                $fatal(1, "bus timeout");
            end
        end while (!wb_ack);
    endtask

    task automatic wb_read(input logic [8:0] addr, output logic [31:0] data);
        @(posedge mac_gmii_rx_clk);
        wb_adr <= addr;
        wb_we  <= 1'b0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wait_ack("read");
        data = wb_dat_o;
        @(posedge mac_gmii_rx_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wb_write(input logic [8:0] addr, input logic [31:0] data);
        @(posedge mac_gmii_rx_clk);
        wb_adr   <= addr;
        wb_dat_i <= data;
        wb_we    <= 1'b1;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wait_ack("write");
        @(posedge mac_gmii_rx_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_status(input logic [3:0] full, input logic [7:0] drops);
        logic [31:0] got;
        wb_read(reg_status_addr, got);
        check_value(got, {16'd0, drops, 4'd0, full}, "status register");
    endtask

    task automatic put_byte(input logic [7:0] b, input logic er);
        @(posedge mac_gmii_rx_clk);
        phy_gmii_rxd   <= b;
        phy_gmii_rx_dv <= 1'b1;
        phy_gmii_rx_er <= er;
    endtask

    // Preamble, SFD, random payload and FCS, then the inter-frame gap
    task automatic send_frame(input int payload_len, input bit flip_fcs, input int err_pos);
        logic [31:0] crc;
        logic [31:0] fcs;
        crc = '1;
        frame_len = payload_len + 4;
        for (int i = 0; i < payload_len; i++) begin
            rng_state = next_random(rng_state);
            frame_bytes[i] = rng_state[7:0];
            crc = crc32_step(crc, frame_bytes[i]);
        end
        fcs = ~crc;
        if (flip_fcs) begin
            fcs[0] = ~fcs[0];
        end
        // FCS goes out low byte first
        for (int k = 0; k < 4; k++) begin
            frame_bytes[payload_len + k] = fcs[8*k +: 8];
        end
        repeat (7) put_byte(8'h55, 1'b0);
        put_byte(8'hD5, 1'b0);
        for (int i = 0; i < frame_len; i++) begin
            put_byte(frame_bytes[i], i == err_pos);
        end
        @(posedge mac_gmii_rx_clk);
        phy_gmii_rxd   <= 8'h00;
        phy_gmii_rx_dv <= 1'b0;
        phy_gmii_rx_er <= 1'b0;
        repeat (11) @(posedge mac_gmii_rx_clk);
    endtask

    // Descriptor in word 0, data from word 1 with the first byte lowest
    task automatic check_slot(input int slot, input bit exp_trunc, input bit exp_err,
                              input bit exp_crc);
        buf_word_u   got;
        logic [31:0] raw;
        logic [31:0] exp_word;
        logic [31:0] mask;
        int          stored;
        int          idx;
        stored = (frame_len > max_frame_bytes) ? max_frame_bytes : frame_len;
        wb_read(9'(slot * slot_words), raw);
        got = raw;
        check_value({16'd0, got.desc.valid, got.desc.truncated, got.desc.rx_err,
                     got.desc.crc_ok, got.desc.len},
                    {16'd0, 1'b1, exp_trunc, exp_err, exp_crc, 12'(stored)},
                    $sformatf("slot %0d descriptor", slot));
        for (int w = 0; w < (stored + 3) / 4; w++) begin
            exp_word = '0;
            mask     = '0;
            for (int b = 0; b < 4; b++) begin
                idx = 4 * w + b;
                // Tail word holds fewer bytes
                if (idx < stored) begin
                    exp_word[8*b +: 8] = frame_bytes[idx];
                    mask[8*b +: 8]     = 8'hff;
                end
            end
            wb_read(9'(slot * slot_words + 1 + w), raw);
            check_value(raw & mask, exp_word, $sformatf("slot %0d word %0d", slot, w + 1));
        end
    endtask

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge mac_gmii_rx_clk);
        $display("Watchdog expired at %0t ns, the test did not finish", $time);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : checker_watch
        wait (u_gmii_rx_subsys.u_gmii_rx_checker.error_count != 0);
        $display("A bus checker assertion failed at %0t ns", $time);
        $display("Simulation failed");
        $fatal(1, "assertion failure");
    end

    initial begin
        rst            = 1'b1;
        phy_gmii_rxd   = 8'h00;
        phy_gmii_rx_dv = 1'b0;
        phy_gmii_rx_er = 1'b0;
        wb_adr         = '0;
        wb_dat_i       = '0;
        wb_we          = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        rng_state      = 32'h9dd4;
        frame_len      = 0;

        repeat (8) @(posedge mac_gmii_rx_clk);
        rst <= 1'b0;
        // Synchronized release
        repeat (4) @(posedge mac_gmii_rx_clk);

        check_status(4'h0, 8'd0);

        // Good frame into slot 0
        send_frame(len_good, 1'b0, -1);
        check_status(4'h1, 8'd0);
        check_slot(0, 1'b0, 1'b0, 1'b1);

        // Corrupt FCS, odd length
        send_frame(len_badfcs, 1'b1, -1);
        check_status(4'h3, 8'd0);
        check_slot(1, 1'b0, 1'b0, 1'b0);

        // rx_er on one payload byte
        send_frame(len_rxer, 1'b0, 5);
        check_status(4'h7, 8'd0);
        check_slot(2, 1'b0, 1'b1, 1'b1);

        // Longer than a slot
        send_frame(len_long, 1'b0, -1);
        check_status(4'hf, 8'd0);
        check_slot(3, 1'b1, 1'b0, 1'b1);

        // No free slot, frame dropped
        send_frame(len_drop, 1'b0, -1);
        check_status(4'hf, 8'd1);

        wb_write(reg_release_addr, 32'h0000_0004);
        check_status(4'hb, 8'd1);

        // Lowest free slot is slot 2 again
        send_frame(len_reuse, 1'b0, -1);
        check_status(4'hf, 8'd1);
        check_slot(2, 1'b0, 1'b0, 1'b1);

        repeat (4) @(posedge mac_gmii_rx_clk);
        if (u_gmii_rx_subsys.u_gmii_rx_checker.error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "bus checker reported errors");
        end
    end

endmodule

// ==== gmii_rx_checker.sv ====
// ##########################################################
// Bus and reset checker for the GMII receive subsystem
// Wishbone acknowledge rules, reset state of the host port
// Bound into gmii_rx_subsys
// ##########################################################

`timescale 1ns/1ns

module gmii_rx_checker
    import gmii_rx_pkg::*;
(
    input logic                  mac_gmii_rx_clk,
    input logic                  rst,
    input logic                  sync_rst,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_ack,
    input logic [slot_count-1:0] slot_full
);

    // Failed assertions so far, watched by the testbench
    int error_count;

    initial error_count = 0;

    // Ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge mac_gmii_rx_clk) disable iff (sync_rst)
        wb_ack |-> (wb_cyc && wb_stb))
    else begin
        $error("wb_ack high outside a Wishbone cycle");
        error_count = error_count + 1;
    end

    // One ack pulse per access
    ack_one_cycle: assert property (@(posedge mac_gmii_rx_clk) disable iff (sync_rst)
        wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack held for more than one cycle");
        error_count = error_count + 1;
    end

    // Quiet host port during and right after reset
    ack_low_in_reset: assert property (@(posedge mac_gmii_rx_clk)
        rst |-> !wb_ack)
    else begin
        $error("wb_ack high while rst is asserted");
        error_count = error_count + 1;
    end

    clean_after_reset: assert property (@(posedge mac_gmii_rx_clk)
        $fell(sync_rst) |-> (!wb_ack && slot_full == '0))
    else begin
        $error("host port not idle when reset released");
        error_count = error_count + 1;
    end

endmodule

bind gmii_rx_subsys gmii_rx_checker u_gmii_rx_checker (
    .mac_gmii_rx_clk (mac_gmii_rx_clk),
    .rst             (rst),
    .sync_rst        (sync_rst),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_ack          (wb_ack),
    .slot_full       (slot_full)
);

// ==== gmii_rx_subsys.sv ====
// ##########################################################
// GMII receive subsystem top level
// PHY input stage, framer, arbiter, buffer RAM, host port
// ##########################################################

`timescale 1ns/1ns

module gmii_rx_subsys
    import gmii_rx_pkg::*;
(
    input  logic        mac_gmii_rx_clk,
    input  logic        rst,
    input  logic [7:0]  phy_gmii_rxd,
    input  logic        phy_gmii_rx_dv,
    input  logic        phy_gmii_rx_er,
    input  logic [8:0]  wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);

    // Registered GMII and local reset
    logic [7:0]                rxd;
    logic                      rx_dv;
    logic                      rx_er;
    logic                      sync_rst;

    // Framer side
    logic                      fr_we;
    logic [buf_addr_width-1:0] fr_addr;
    buf_word_u                 fr_wdata;
    logic                      slot_done;
    logic [1:0]                slot_id;
    logic                      frame_drop;
    logic [slot_count-1:0]     slot_full;

    // Host side
    logic                      host_req;
    logic [buf_addr_width-1:0] host_addr;
    logic                      host_gnt;
    logic [31:0]               host_rdata;

    // RAM port
    logic                      ram_en;
    logic                      ram_we;
    logic [buf_addr_width-1:0] ram_addr;
    logic [31:0]               ram_wdata;
    logic [31:0]               ram_rdata;

    gmii_phy_rx_if u_gmii_phy_rx_if (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .rxd             (rxd),
        .rx_dv           (rx_dv),
        .rx_er           (rx_er),
        .sync_rst        (sync_rst)
    );

    gmii_rx_framer u_gmii_rx_framer (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .sync_rst        (sync_rst),
        .rxd             (rxd),
        .rx_dv           (rx_dv),
        .rx_er           (rx_er),
        .slot_full       (slot_full),
        .fr_we           (fr_we),
        .fr_addr         (fr_addr),
        .fr_wdata        (fr_wdata),
        .slot_done       (slot_done),
        .slot_id         (slot_id),
        .frame_drop      (frame_drop)
    );

    frame_buf_arbiter u_frame_buf_arbiter (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .sync_rst        (sync_rst),
        .fr_we           (fr_we),
        .fr_addr         (fr_addr),
        .fr_wdata        (fr_wdata),
        .host_req        (host_req),
        .host_addr       (host_addr),
        .ram_rdata       (ram_rdata),
        .host_gnt        (host_gnt),
        .ram_en          (ram_en),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .host_rdata      (host_rdata)
    );

    frame_buf_ram u_frame_buf_ram (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .ram_en          (ram_en),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_rdata       (ram_rdata)
    );

    // Host sees only the steered read data
    wb_frame_host u_wb_frame_host (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .sync_rst        (sync_rst),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_we           (wb_we),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .slot_done       (slot_done),
        .slot_id         (slot_id),
        .frame_drop      (frame_drop),
        .host_gnt        (host_gnt),
        .ram_rdata       (host_rdata),
        .wb_dat_o        (wb_dat_o),
        .wb_ack          (wb_ack),
        .slot_full       (slot_full),
        .host_req        (host_req),
        .host_addr       (host_addr)
    );

endmodule

// ==== wb_frame_host.sv ====
// ##########################################################
// Wishbone classic host port
// Buffer read window, slot status and release
// Saturating dropped frame counter
// ##########################################################

`timescale 1ns/1ns

module wb_frame_host
    import gmii_rx_pkg::*;
(
    input  logic                      mac_gmii_rx_clk,
    input  logic                      sync_rst,
    input  logic [8:0]                wb_adr,
    input  logic [31:0]               wb_dat_i,
    input  logic                      wb_we,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      slot_done,
    input  logic [1:0]                slot_id,
    input  logic                      frame_drop,
    input  logic                      host_gnt,
    input  logic [31:0]               ram_rdata,
    output logic [31:0]               wb_dat_o,
    output logic                      wb_ack,
    output logic [slot_count-1:0]     slot_full,
    output logic                      host_req,
    output logic [buf_addr_width-1:0] host_addr
);

    logic                  access;
    logic                  buf_rd;
    logic                  reg_acc;
    logic                  rd_wait;
    logic [7:0]            drop_count;
    logic [slot_count-1:0] release_mask;
    logic [slot_count-1:0] done_mask;

    // New cycle only while no ack is out
    assign access = wb_cyc & wb_stb & ~wb_ack;

    // Buffer reads go through the arbiter
    assign buf_rd = access & ~wb_adr[8] & ~wb_we;

    // Registers and ignored buffer writes ack in one cycle
    assign reg_acc = access & (wb_adr[8] | wb_we);

    // Hold off while the granted read is in flight
    assign host_req  = buf_rd & ~rd_wait;
    assign host_addr = wb_adr[buf_addr_width-1:0];

    // Write-one-to-clear release
    assign release_mask = (reg_acc && wb_we && wb_adr == reg_release_addr) ?
                          wb_dat_i[slot_count-1:0] : '0;

    assign done_mask = slot_done ? (slot_count'(1) << slot_id) : '0;

    always_ff @(posedge mac_gmii_rx_clk or posedge sync_rst) begin
        if (sync_rst) begin
            wb_ack     <= 1'b0;
            rd_wait    <= 1'b0;
            slot_full  <= '0;
            drop_count <= '0;
        end else begin
            // Grant, then RAM data, then ack
            rd_wait   <= host_gnt;
            wb_ack    <= reg_acc | rd_wait;
            slot_full <= (slot_full & ~release_mask) | done_mask;
            if (frame_drop && drop_count != 8'hff) begin
                drop_count <= drop_count + 8'd1;
            end
        end
    end

    // Read data, held until the next access
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (rd_wait) begin
            wb_dat_o <= ram_rdata;
        end else if (reg_acc) begin
            if (wb_adr == reg_status_addr) begin
                wb_dat_o <= {16'd0, drop_count, 8'(slot_full)};
            end else begin
                wb_dat_o <= '0;
            end
        end
    end

endmodule

// ==== frame_buf_ram.sv ====
// ##########################################################
// Frame buffer RAM, 256 x 32, single port
// Registered read, read-first on write
// ##########################################################

`timescale 1ns/1ns

module frame_buf_ram
    import gmii_rx_pkg::*;
(
    input  logic                      mac_gmii_rx_clk,
    input  logic                      ram_en,
    input  logic                      ram_we,
    input  logic [buf_addr_width-1:0] ram_addr,
    input  logic [31:0]               ram_wdata,
    output logic [31:0]               ram_rdata
);

    logic [31:0] mem [0:(1 << buf_addr_width) - 1];

    // Block RAM template
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

// ==== frame_buf_arbiter.sv ====
// ##########################################################
// Buffer RAM arbiter
// Framer writes first, host reads in the gaps
// Read data returned only for granted host reads
// ##########################################################

`timescale 1ns/1ns

module frame_buf_arbiter
    import gmii_rx_pkg::*;
(
    input  logic                      mac_gmii_rx_clk,
    input  logic                      sync_rst,
    input  logic                      fr_we,
    input  logic [buf_addr_width-1:0] fr_addr,
    input  buf_word_u                 fr_wdata,
    input  logic                      host_req,
    input  logic [buf_addr_width-1:0] host_addr,
    input  logic [31:0]               ram_rdata,
    output logic                      host_gnt,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [buf_addr_width-1:0] ram_addr,
    output logic [31:0]               ram_wdata,
    output logic [31:0]               host_rdata
);

    logic host_rd_pend;

    // Framer never waits
    assign host_gnt  = host_req & ~fr_we;
    assign ram_en    = fr_we | host_req;
    assign ram_we    = fr_we;
    assign ram_addr  = fr_we ? fr_addr : host_addr;
    assign ram_wdata = fr_wdata;

    // Granted read, data due next cycle
    always_ff @(posedge mac_gmii_rx_clk or posedge sync_rst) begin
        if (sync_rst) begin
            host_rd_pend <= 1'b0;
        end else begin
            host_rd_pend <= host_gnt;
        end
    end

    assign host_rdata = host_rd_pend ? ram_rdata : '0;

endmodule

// ==== gmii_rx_framer.sv ====
// ##########################################################
// GMII receive framer
// Preamble and SFD detection, slot choice, byte packing
// FCS check, truncation, descriptor write into word 0
// ##########################################################

`timescale 1ns/1ns

module gmii_rx_framer
    import gmii_rx_pkg::*;
(
    input  logic                      mac_gmii_rx_clk,
    input  logic                      sync_rst,
    input  logic [7:0]                rxd,
    input  logic                      rx_dv,
    input  logic                      rx_er,
    input  logic [slot_count-1:0]     slot_full,
    output logic                      fr_we,
    output logic [buf_addr_width-1:0] fr_addr,
    output buf_word_u                 fr_wdata,
    output logic                      slot_done,
    output logic [1:0]                slot_id,
    output logic                      frame_drop
);

    logic [1:0]  state;
    logic [11:0] byte_cnt;
    logic [31:0] crc;
    logic        store_en;
    logic        trunc;
    logic        err;
    logic        free_any;
    logic [1:0]  free_idx;
    logic        stored_byte;
    buf_word_u   word_buf;
    buf_word_u   packed_w;
    buf_word_u   desc_w;

    // Lowest free slot wins, so scan downwards
    always_comb begin
        free_any = 1'b0;
        free_idx = '0;
        for (int i = slot_count - 1; i >= 0; i--) begin
            if (!slot_full[i]) begin
                free_any = 1'b1;
                free_idx = 2'(i);
            end
        end
    end

    // Bytes past the slot capacity are counted only
    assign stored_byte = (byte_cnt < 12'(max_frame_bytes));

    // Current byte merged into the word being built
    always_comb begin
        packed_w = word_buf;
        packed_w.data[byte_cnt[1:0]] = rxd;
    end

    // Descriptor from the frame totals
    always_comb begin
        desc_w = '0;
        desc_w.desc.valid     = 1'b1;
        desc_w.desc.truncated = trunc;
        desc_w.desc.rx_err    = err;
        desc_w.desc.crc_ok    = (crc == crc32_residue);
        desc_w.desc.len       = trunc ? 12'(max_frame_bytes) : byte_cnt;
    end

    always_ff @(posedge mac_gmii_rx_clk or posedge sync_rst) begin
        if (sync_rst) begin
            state      <= fr_idle;
            byte_cnt   <= '0;
            crc        <= '1;
            store_en   <= 1'b0;
            trunc      <= 1'b0;
            err        <= 1'b0;
            fr_we      <= 1'b0;
            fr_addr    <= '0;
            slot_done  <= 1'b0;
            slot_id    <= '0;
            frame_drop <= 1'b0;
        end else begin
            // Single-cycle strobes
            fr_we      <= 1'b0;
            slot_done  <= 1'b0;
            frame_drop <= 1'b0;
            case (state)
                fr_idle: begin
                    if (rx_dv && rxd == 8'h55) begin
                        state <= fr_preamble;
                    end
                end
                fr_preamble: begin
                    byte_cnt <= '0;
                    crc      <= '1;
                    trunc    <= 1'b0;
                    err      <= 1'b0;
                    if (!rx_dv) begin
                        state <= fr_idle;
                    end else if (rxd == 8'hD5) begin
                        // SFD seen, claim a slot or drop the frame
                        state      <= fr_payload;
                        store_en   <= free_any;
                        slot_id    <= free_idx;
                        frame_drop <= ~free_any;
                    end else if (rxd != 8'h55) begin
                        state <= fr_idle;
                    end
                end
                fr_payload: begin
                    if (rx_dv) begin
                        crc <= crc32_step(crc, rxd);
                        err <= err | rx_er;
                        if (byte_cnt != 12'hfff) begin
                            byte_cnt <= byte_cnt + 12'd1;
                        end
                        if (!stored_byte) begin
                            trunc <= 1'b1;
                        end else if (byte_cnt[1:0] == 2'd3) begin
                            // Full word, data starts at word 1
                            fr_we   <= store_en;
                            fr_addr <= {slot_id, byte_cnt[7:2] + 6'd1};
                        end
                    end else begin
                        state <= fr_finish;
                        // Flush the partial tail word
                        if (byte_cnt[1:0] != 2'd0 && !trunc) begin
                            fr_we   <= store_en;
                            fr_addr <= {slot_id, byte_cnt[7:2] + 6'd1};
                        end
                    end
                end
                fr_finish: begin
                    state     <= fr_idle;
                    fr_we     <= store_en;
                    fr_addr   <= {slot_id, 6'd0};
                    slot_done <= store_en;
                end
                default: state <= fr_idle;
            endcase
        end
    end

    // Word assembly and write data
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (state == fr_payload) begin
            if (rx_dv) begin
                fr_wdata <= packed_w;
                if (byte_cnt[1:0] == 2'd3) begin
                    word_buf <= '0;
                end else begin
                    word_buf <= packed_w;
                end
            end else begin
                fr_wdata <= word_buf;
            end
        end else begin
            // Descriptor ready for the finish write
            word_buf <= '0;
            fr_wdata <= desc_w;
        end
    end

endmodule

// ==== gmii_phy_rx_if.sv ====
// ##########################################################
// PHY side GMII receive input stage
// Boundary registers for rxd, rx_dv, rx_er
// Reset synchronizer with four-stage release
// ##########################################################

`timescale 1ns/1ns

module gmii_phy_rx_if (
    input  logic       mac_gmii_rx_clk,
    input  logic       rst,
    input  logic [7:0] phy_gmii_rxd,
    input  logic       phy_gmii_rx_dv,
    input  logic       phy_gmii_rx_er,
    output logic [7:0] rxd,
    output logic       rx_dv,
    output logic       rx_er,
    output logic       sync_rst
);

    logic [3:0] rst_shift;

    // Assert at once, release after four edges
    always_ff @(posedge mac_gmii_rx_clk or posedge rst) begin
        if (rst) begin
            rst_shift <= 4'hf;
        end else begin
            rst_shift <= {1'b0, rst_shift[3:1]};
        end
    end

    assign sync_rst = rst_shift[0];

    // Qualifiers cleared so the framer sees a quiet line in reset
    always_ff @(posedge mac_gmii_rx_clk or posedge rst) begin
        if (rst) begin
            rx_dv <= 1'b0;
            rx_er <= 1'b0;
        end else begin
            rx_dv <= phy_gmii_rx_dv;
            rx_er <= phy_gmii_rx_er;
        end
    end

    // Data byte, one cycle of latency like the qualifiers
    always_ff @(posedge mac_gmii_rx_clk) begin
        rxd <= phy_gmii_rxd;
    end

endmodule

// ==== gmii_rx_pkg.sv ====
// ##########################################################
// Shared definitions for the GMII receive subsystem
// Buffer geometry, host register map, framer state codes
// Buffer word union, CRC-32 byte step and residue
// ##########################################################

package gmii_rx_pkg;

    // Buffer geometry
    localparam int slot_count      = 4;
    localparam int slot_words      = 64;
    localparam int max_frame_bytes = 252;
    localparam int buf_addr_width  = 8;

    // Host registers live above the buffer window (address bit 8 set)
    localparam logic [8:0] reg_status_addr  = 9'h100;
    localparam logic [8:0] reg_release_addr = 9'h101;

    // Framer states
    localparam logic [1:0] fr_idle     = 2'd0;
    localparam logic [1:0] fr_preamble = 2'd1;
    localparam logic [1:0] fr_payload  = 2'd2;
    localparam logic [1:0] fr_finish   = 2'd3;

    // Register value after a good frame plus its FCS
    localparam logic [31:0] crc32_residue = 32'hDEBB20E3;

    // One buffer word, read as frame bytes or as a slot descriptor
    typedef union packed {
        // First received byte in data[0]
        logic [3:0][7:0] data;
        struct packed {
            logic        valid;
            logic        truncated;
            logic        rx_err;
            logic        crc_ok;
            logic [15:0] rsvd;
            // Length in bytes, FCS included
            logic [11:0] len;
        } desc;
    } buf_word_u;

    // Reflected Ethernet CRC-32, one byte, LSB first
    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

endpackage
